// ==== led_wave_top.f ====
+incdir+design
design/led_pkg.sv
design/band_phase_regs.sv
design/wave_painter.sv
design/frame_buffer.sv
design/strip_sender.sv
design/led_wave_top.sv
bench/led_wave_props.sv
bench/led_wave_tb.sv

// ==== Makefile ====
# Verilator build and run of the LED wave generator testbench

TB_TOP = led_wave_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TB_TOP) -f led_wave_top.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== bench/led_wave_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the LED wave generator. A strip model returns credits
// for received records and a table of frames is checked against a
// reference model of the band and phase rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

module led_wave_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import led_pkg::*;

  localparam int MODE_PROMPT = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_STALL = 2;
  localparam int STALL_CYCLES = 200;
  localparam int RECORD_TIMEOUT = 1000;
  localparam int NUM_ROWS = 6;

  localparam int SINE_REF [`SINE_STEPS] = '{
    50, 56, 62, 68, 75, 80, 85, 89, 93, 96,
    98, 99, 99, 99, 97, 95, 92, 88, 84, 78,
    72, 67, 60, 53, 47, 40, 33, 28, 22, 16,
    12,  8,  4,  2,  0,  0,  0,  1,  3,  5,
     9, 14, 18, 24, 30, 36, 43
  };

  // Rows are bands top, middle, bottom and columns blue, green, red
  localparam int START_PH [3][3] = '{
    '{`START_TOP_BLUE, `START_TOP_GREEN, `START_TOP_RED},
    '{`START_MIDDLE_BLUE, `START_MIDDLE_GREEN, `START_MIDDLE_RED},
    '{`START_BOTTOM_BLUE, `START_BOTTOM_GREEN, `START_BOTTOM_RED}
  };
  localparam int INC_PH [3][3] = '{
    '{`INC_TOP_BLUE, `INC_TOP_GREEN, `INC_TOP_RED},
    '{`INC_MIDDLE_BLUE, `INC_MIDDLE_GREEN, `INC_MIDDLE_RED},
    '{`INC_BOTTOM_BLUE, `INC_BOTTOM_GREEN, `INC_BOTTOM_RED}
  };

  typedef struct packed {
    int frame;
    int mode;
    int mid_pixel;
    int top_blue;
    int mid_blue;
    int bot_blue;
  } frame_row_t;

  // Blue levels at pixel 0, the middle pixel and pixel 46
  localparam frame_row_t ROWS [NUM_ROWS] = '{
    '{0, MODE_PROMPT, 21, 98, 68, 12},
    '{1, MODE_RANDOM, 23, 99, 80, 8},
    '{2, MODE_STALL, 25, 92, 89, 4},
    '{3, MODE_RANDOM, 27, 78, 96, 2},
    '{4, MODE_PROMPT, 30, 60, 99, 0},
    '{5, MODE_RANDOM, 31, 40, 99, 0}
  };

  logic         dostring_clk;
  logic         rst_n;
  logic         credit_return = 1'b0;
  logic         rec_valid;
  record_kind_e rec_kind;
  level_t       rec_blue;
  level_t       rec_green;
  level_t       rec_red;

  record_kind_e kind_q [$];
  int           blue_q [$];
  int           green_q [$];
  int           red_q [$];
  int           due_q [$];
  logic [31:0]  lfsr_state = 32'h0096_2712;
  int           model_credits = `CREDIT_MAX;
  int           cycle_cnt = 0;
  int           return_delay;
  int           credit_mode = MODE_PROMPT;
  int           stall_until = 0;
  int           protocol_errors = 0;
  int           mismatch_count = 0;
  int           other_count = 0;
  int           frames_done = 0;
  bit           timed_out = 1'b0;

  led_wave_top i_dut (
    .dostring_clk  (dostring_clk),
    .rst_n         (rst_n),
    .credit_return (credit_return),
    .rec_valid     (rec_valid),
    .rec_kind      (rec_kind),
    .rec_blue      (rec_blue),
    .rec_green     (rec_green),
    .rec_red       (rec_red)
  );

  bind strip_sender led_wave_props i_props (
    .dostring_clk  (dostring_clk),
    .rst_n         (rst_n),
    .rec_valid     (rec_valid),
    .credit_return (credit_return),
    .credit_cnt    (credit_cnt)
  );

  initial
  begin
    dostring_clk = 1'b0;
    forever #10 dostring_clk = ~dostring_clk;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h8020_0003;
    return n;
  endfunction

  task automatic draw_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic int middle_pixel(int frame);
    return SINE_REF[frame % `SINE_STEPS] / 3 + `MIDDLE_OFFSET;
  endfunction

  function automatic int band_level(int frame, int band, int color);
    return SINE_REF[(START_PH[band][color] + frame * INC_PH[band][color]) % `SINE_STEPS];
  endfunction

  function automatic string color_port(int color);
    string name;
    case (color)
      0: name = "rec_blue";
      1: name = "rec_green";
      default: name = "rec_red";
    endcase
    return name;
  endfunction

  // Strip model that counts credits, captures records and returns credits
  always @(posedge dostring_clk)
  begin
    if (!rst_n)
    begin
      if (rec_valid)
      begin
        protocol_errors++;
        $display("rec_valid was high during reset at %0t", $time);
      end
      credit_return <= 1'b0;
    end
    else
    begin
      cycle_cnt++;
      if (rec_valid)
      begin
        if (model_credits == 0)
        begin
          protocol_errors++;
          $display("a record arrived at %0t while the strip held no credit", $time);
        end
        kind_q.push_back(rec_kind);
        blue_q.push_back(int'(rec_blue));
        green_q.push_back(int'(rec_green));
        red_q.push_back(int'(rec_red));
        return_delay = 0;
        if (credit_mode == MODE_RANDOM)
          draw_bits(3, return_delay);
        due_q.push_back(cycle_cnt + return_delay);
        model_credits--;
      end
      if (credit_return)
        model_credits++;
      if (due_q.size() != 0 && due_q[0] <= cycle_cnt && cycle_cnt >= stall_until)
      begin
        void'(due_q.pop_front());
        credit_return <= 1'b1;
      end
      else
        credit_return <= 1'b0;
    end
  end

  task automatic wait_record(output bit got);
    int waited;
    waited = 0;
    while (kind_q.size() == 0 && waited < RECORD_TIMEOUT)
    begin
      @(negedge dostring_clk);
      waited++;
    end
    got = (kind_q.size() != 0);
  endtask

  task automatic check_pixel(input int row, input int pixel, input int b, input int g,
                             input int r);
    int frame;
    int mid;
    int band;
    int hand_blue;
    int got_lvl [3];
    int exp_lvl;
    frame = ROWS[row].frame;
    mid = middle_pixel(frame);
    band = (pixel < mid) ? 0 : ((pixel == mid) ? 1 : 2);
    got_lvl[0] = b;
    got_lvl[1] = g;
    got_lvl[2] = r;
    for (int c = 0; c < 3; c++)
    begin
      exp_lvl = band_level(frame, band, c);
      if (got_lvl[c] != exp_lvl)
      begin
        mismatch_count++;
        $display("mismatch at %0t: %s frame %0d pixel %0d got %0d expected %0d",
                 $time, color_port(c), frame, pixel, got_lvl[c], exp_lvl);
      end
    end
    hand_blue = -1;
    if (pixel == 0)
      hand_blue = ROWS[row].top_blue;
    else if (pixel == ROWS[row].mid_pixel)
      hand_blue = ROWS[row].mid_blue;
    else if (pixel == `LED_PIXELS - 1)
      hand_blue = ROWS[row].bot_blue;
    if (hand_blue >= 0 && b != hand_blue)
    begin
      mismatch_count++;
      $display("mismatch at %0t: rec_blue frame %0d pixel %0d got %0d expected %0d",
               $time, frame, pixel, b, hand_blue);
    end
  endtask

  task automatic check_frame(input int row);
    int frame;
    int b;
    int g;
    int r;
    bit got;
    record_kind_e kind;
    record_kind_e exp_kind;
    frame = ROWS[row].frame;
    if (frame != frames_done || middle_pixel(frame) != ROWS[row].mid_pixel)
    begin
      other_count++;
      $display("table row %0d disagrees with the frame order or the band rule", row);
    end
    for (int k = 0; k < `LED_PIXELS + 2; k++)
    begin
      wait_record(got);
      if (!got)
      begin
        other_count++;
        timed_out = 1'b1;
        $display("no record %0d of frame %0d arrived within %0d cycles",
                 k, frame, RECORD_TIMEOUT);
        return;
      end
      kind = kind_q.pop_front();
      b = blue_q.pop_front();
      g = green_q.pop_front();
      r = red_q.pop_front();
      if (k == 0)
        exp_kind = rec_start;
      else if (k == `LED_PIXELS + 1)
        exp_kind = rec_end;
      else
        exp_kind = rec_pixel;
      if (kind != exp_kind)
      begin
        mismatch_count++;
        $display("mismatch at %0t: rec_kind frame %0d record %0d got %s expected %s",
                 $time, frame, k, kind.name(), exp_kind.name());
      end
      else if (kind == rec_pixel)
        check_pixel(row, k - 1, b, g, r);
    end
    frames_done++;
  endtask

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge dostring_clk);
    rst_n <= 1'b1;
    @(negedge dostring_clk);
    for (int row = 0; row < NUM_ROWS && !timed_out; row++)
    begin
      credit_mode = ROWS[row].mode;
      if (ROWS[row].mode == MODE_STALL)
        stall_until = cycle_cnt + STALL_CYCLES;
      check_frame(row);
    end
    $display("frames %0d, mismatches %0d, protocol errors %0d, other errors %0d",
             frames_done, mismatch_count, protocol_errors, other_count);
    if (mismatch_count == 0 && protocol_errors == 0 && other_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/led_wave_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit rule assertions for the strip sender. Bound to every
// strip_sender instance from the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

module led_wave_props #(
  parameter int CNT_W = $clog2(`CREDIT_MAX + 1)
) (
  input logic             dostring_clk,
  input logic             rst_n,
  input logic             rec_valid,
  input logic             credit_return,
  input logic [CNT_W-1:0] credit_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  int shadow_credits;

  // Credits as seen on the record interface, counted apart from the sender
  always_ff @(posedge dostring_clk or negedge rst_n)
  begin
    if (!rst_n)
      shadow_credits <= `CREDIT_MAX;
    else
      shadow_credits <= shadow_credits - int'(rec_valid) + int'(credit_return);
  end

  credit_gates_record: assert property (
    @(posedge dostring_clk) disable iff (!rst_n)
    rec_valid |-> (shadow_credits > 0)
  ) else $error("record issued with no credit left on the interface");

  credit_within_limit: assert property (
    @(posedge dostring_clk) disable iff (!rst_n)
    credit_cnt <= CNT_W'(`CREDIT_MAX)
  ) else $error("credit counter above its maximum");

  // Reset is asynchronous, so the output must be quiet on every edge in reset
  quiet_in_reset: assert property (
    @(posedge dostring_clk)
    !rst_n |-> !rec_valid
  ) else $error("rec_valid high while reset is asserted");

endmodule

`default_nettype wire

// ==== design/led_wave_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the LED wave generator. Connects the phase registers,
// painter, frame buffer and sender; the record stream with its
// credit return is the only interface to the outside.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module led_wave_top (
  input  logic                  dostring_clk,
  input  logic                  rst_n,
  input  logic                  credit_return,
  output logic                  rec_valid,
  output led_pkg::record_kind_e rec_kind,
  output led_pkg::level_t       rec_blue,
  output led_pkg::level_t       rec_green,
  output led_pkg::level_t       rec_red
);
  import led_pkg::*;

  phase_t     top_blue;
  phase_t     top_green;
  phase_t     top_red;
  phase_t     middle_blue;
  phase_t     middle_green;
  phase_t     middle_red;
  phase_t     bottom_blue;
  phase_t     bottom_green;
  phase_t     bottom_red;
  phase_t     frame_idx;
  logic       frame_painted;
  logic       working_free;
  logic       working_full;
  logic       wr_en;
  pixel_idx_t wr_pixel;
  level_t     wr_blue;
  level_t     wr_green;
  level_t     wr_red;
  pixel_idx_t rd_pixel;
  level_t     rd_blue;
  level_t     rd_green;
  level_t     rd_red;
  logic       current_ready;
  logic       current_release;

  band_phase_regs i_phase_regs (
    .dostring_clk  (dostring_clk),
    .rst_n         (rst_n),
    .frame_painted (frame_painted),
    .top_blue      (top_blue),
    .top_green     (top_green),
    .top_red       (top_red),
    .middle_blue   (middle_blue),
    .middle_green  (middle_green),
    .middle_red    (middle_red),
    .bottom_blue   (bottom_blue),
    .bottom_green  (bottom_green),
    .bottom_red    (bottom_red),
    .frame_idx     (frame_idx)
  );

  wave_painter i_painter (
    .dostring_clk  (dostring_clk),
    .rst_n         (rst_n),
    .working_free  (working_free),
    .top_blue      (top_blue),
    .top_green     (top_green),
    .top_red       (top_red),
    .middle_blue   (middle_blue),
    .middle_green  (middle_green),
    .middle_red    (middle_red),
    .bottom_blue   (bottom_blue),
    .bottom_green  (bottom_green),
    .bottom_red    (bottom_red),
    .frame_idx     (frame_idx),
    .wr_en         (wr_en),
    .wr_pixel      (wr_pixel),
    .wr_blue       (wr_blue),
    .wr_green      (wr_green),
    .wr_red        (wr_red),
    .working_full  (working_full),
    .frame_painted (frame_painted)
  );

  frame_buffer i_frame_buffer (
    .dostring_clk    (dostring_clk),
    .rst_n           (rst_n),
    .wr_en           (wr_en),
    .wr_pixel        (wr_pixel),
    .wr_blue         (wr_blue),
    .wr_green        (wr_green),
    .wr_red          (wr_red),
    .working_full    (working_full),
    .working_free    (working_free),
    .rd_pixel        (rd_pixel),
    .rd_blue         (rd_blue),
    .rd_green        (rd_green),
    .rd_red          (rd_red),
    .current_ready   (current_ready),
    .current_release (current_release)
  );

  strip_sender i_sender (
    .dostring_clk    (dostring_clk),
    .rst_n           (rst_n),
    .current_ready   (current_ready),
    .current_release (current_release),
    .credit_return   (credit_return),
    .rd_pixel        (rd_pixel),
    .rd_blue         (rd_blue),
    .rd_green        (rd_green),
    .rd_red          (rd_red),
    .rec_valid       (rec_valid),
    .rec_kind        (rec_kind),
    .rec_blue        (rec_blue),
    .rec_green       (rec_green),
    .rec_red         (rec_red)
  );

endmodule

`default_nettype wire

// ==== design/strip_sender.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streams the current frame as records: start, one per pixel, end.
// Every record costs a credit and credit_return gives one back, so
// the FSM stalls in place whenever the credit counter is empty.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

module strip_sender (
  input  logic                  dostring_clk,
  input  logic                  rst_n,
  input  logic                  current_ready,
  output logic                  current_release,
  input  logic                  credit_return,
  output led_pkg::pixel_idx_t   rd_pixel,
  input  led_pkg::level_t       rd_blue,
  input  led_pkg::level_t       rd_green,
  input  led_pkg::level_t       rd_red,
  output logic                  rec_valid,
  output led_pkg::record_kind_e rec_kind,
  output led_pkg::level_t       rec_blue,
  output led_pkg::level_t       rec_green,
  output led_pkg::level_t       rec_red
);
  import led_pkg::*;

  localparam int CREDIT_W = $clog2(`CREDIT_MAX + 1);

  send_state_e         state;
  pixel_idx_t          pixel_cnt;
  logic [CREDIT_W-1:0] credit_cnt;
  logic                record_slot;

  assign record_slot = (state == send_start) || (state == send_pixel)
                     || (state == send_end);
  assign rec_valid       = record_slot && (credit_cnt != '0);
  assign current_release = (state == send_release);
  assign rd_pixel        = pixel_cnt;

  // Color fields carry data only on pixel records
  assign rec_blue  = (state == send_pixel) ? rd_blue : '0;
  assign rec_green = (state == send_pixel) ? rd_green : '0;
  assign rec_red   = (state == send_pixel) ? rd_red : '0;

  always_comb
  begin
    case (state)
      send_start: rec_kind = rec_start;
      send_end:   rec_kind = rec_end;
      default:    rec_kind = rec_pixel;
    endcase
  end

  always_ff @(posedge dostring_clk or negedge rst_n)
  begin
    if (!rst_n)
      credit_cnt <= CREDIT_W'(`CREDIT_MAX);
    else if (rec_valid && !credit_return)
      credit_cnt <= credit_cnt - 1'b1;
    else if (!rec_valid && credit_return)
      credit_cnt <= credit_cnt + 1'b1;
  end

  always_ff @(posedge dostring_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= send_idle;
      pixel_cnt <= '0;
    end
    else
    begin
      case (state)
        send_idle:
          if (current_ready)
            state <= send_start;
        send_start:
          if (rec_valid)
          begin
            pixel_cnt <= '0;
            state     <= send_pixel;
          end
        send_pixel:
          if (rec_valid)
          begin
            if (pixel_cnt == pixel_idx_t'(`LED_PIXELS - 1))
              state <= send_end;
            else
              pixel_cnt <= pixel_cnt + 1'b1;
          end
        send_end:
          if (rec_valid)
            state <= send_release;
        default:
          state <= send_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/frame_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Double buffer between painter and sender. The painter fills the
// working array; once it is full and the sender has let go of the
// current array, the copy FSM moves it over one byte per cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

module frame_buffer (
  input  logic                dostring_clk,
  input  logic                rst_n,
  input  logic                wr_en,
  input  led_pkg::pixel_idx_t wr_pixel,
  input  led_pkg::level_t     wr_blue,
  input  led_pkg::level_t     wr_green,
  input  led_pkg::level_t     wr_red,
  input  logic                working_full,
  output logic                working_free,
  input  led_pkg::pixel_idx_t rd_pixel,
  output led_pkg::level_t     rd_blue,
  output led_pkg::level_t     rd_green,
  output led_pkg::level_t     rd_red,
  output logic                current_ready,
  input  logic                current_release
);
  import led_pkg::*;

  localparam int         FRAME_BYTES = `LED_PIXELS * 3;
  localparam byte_addr_t LAST_BYTE   = byte_addr_t'(FRAME_BYTES - 1);

  level_t      working_mem [FRAME_BYTES];
  level_t      current_mem [FRAME_BYTES];
  copy_state_e copy_state;
  byte_addr_t  copy_addr;
  byte_addr_t  wr_base;
  byte_addr_t  rd_base;

  // Each pixel is three bytes, blue first
  assign wr_base = {2'b00, wr_pixel} + {1'b0, wr_pixel, 1'b0};
  assign rd_base = {2'b00, rd_pixel} + {1'b0, rd_pixel, 1'b0};

  assign rd_blue  = current_mem[rd_base];
  assign rd_green = current_mem[rd_base + 8'd1];
  assign rd_red   = current_mem[rd_base + 8'd2];

  always_ff @(posedge dostring_clk)
  begin
    if (wr_en)
    begin
      working_mem[wr_base]        <= wr_blue;
      working_mem[wr_base + 8'd1] <= wr_green;
      working_mem[wr_base + 8'd2] <= wr_red;
    end
  end

  always_ff @(posedge dostring_clk)
  begin
    if (copy_state == copy_run)
      current_mem[copy_addr] <= working_mem[copy_addr];
  end

  // A low working_free outside of a copy means the working frame is full
  always_ff @(posedge dostring_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      copy_state    <= copy_idle;
      copy_addr     <= '0;
      working_free  <= 1'b1;
      current_ready <= 1'b0;
    end
    else
    begin
      if (working_full)
        working_free <= 1'b0;
      if (current_release)
        current_ready <= 1'b0;
      case (copy_state)
        copy_idle:
        begin
          if (!working_free && !current_ready)
          begin
            copy_addr  <= '0;
            copy_state <= copy_run;
          end
        end
        default:
        begin
          if (copy_addr == LAST_BYTE)
          begin
            copy_state    <= copy_idle;
            working_free  <= 1'b1;
            current_ready <= 1'b1;
          end
          else
            copy_addr <= copy_addr + 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/wave_painter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Paints one frame of three sine bands into the working buffer, one
// pixel per cycle, whenever the frame buffer reports it free. The
// middle band position follows the sine of the frame index.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

module wave_painter (
  input  logic                dostring_clk,
  input  logic                rst_n,
  input  logic                working_free,
  input  led_pkg::phase_t     top_blue,
  input  led_pkg::phase_t     top_green,
  input  led_pkg::phase_t     top_red,
  input  led_pkg::phase_t     middle_blue,
  input  led_pkg::phase_t     middle_green,
  input  led_pkg::phase_t     middle_red,
  input  led_pkg::phase_t     bottom_blue,
  input  led_pkg::phase_t     bottom_green,
  input  led_pkg::phase_t     bottom_red,
  input  led_pkg::phase_t     frame_idx,
  output logic                wr_en,
  output led_pkg::pixel_idx_t wr_pixel,
  output led_pkg::level_t     wr_blue,
  output led_pkg::level_t     wr_green,
  output led_pkg::level_t     wr_red,
  output logic                working_full,
  output logic                frame_painted
);
  import led_pkg::*;

  paint_state_e state;
  pixel_idx_t   pixel_cnt;
  pixel_idx_t   middle_pos;
  band_e        band;

  assign wr_en         = (state == paint_write);
  assign wr_pixel      = pixel_cnt;
  assign working_full  = (state == paint_done);
  assign frame_painted = (state == paint_done);

  always_comb
  begin
    if (pixel_cnt < middle_pos)
      band = band_top;
    else if (pixel_cnt == middle_pos)
      band = band_middle;
    else
      band = band_bottom;
  end

  always_comb
  begin
    case (band)
      band_top:
      begin
        wr_blue  = sine_level(top_blue);
        wr_green = sine_level(top_green);
        wr_red   = sine_level(top_red);
      end
      band_middle:
      begin
        wr_blue  = sine_level(middle_blue);
        wr_green = sine_level(middle_green);
        wr_red   = sine_level(middle_red);
      end
      default:
      begin
        wr_blue  = sine_level(bottom_blue);
        wr_green = sine_level(bottom_green);
        wr_red   = sine_level(bottom_red);
      end
    endcase
  end

  always_ff @(posedge dostring_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= paint_idle;
      pixel_cnt  <= '0;
      middle_pos <= '0;
    end
    else
    begin
      case (state)
        paint_idle:
        begin
          if (working_free)
          begin
            // Uses the index of the frame about to be painted
            middle_pos <= pixel_idx_t'(sine_level(frame_idx) / 8'd3)
                        + pixel_idx_t'(`MIDDLE_OFFSET);
            pixel_cnt  <= '0;
            state      <= paint_write;
          end
        end
        paint_write:
        begin
          if (pixel_cnt == pixel_idx_t'(`LED_PIXELS - 1))
            state <= paint_done;
          else
            pixel_cnt <= pixel_cnt + 1'b1;
        end
        default:
          state <= paint_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/band_phase_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phase registers that steer the wave painter. Holds the nine band
// channel phases and the frame index, all stepped once per painted
// frame and wrapped at the sine table size.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

module band_phase_regs (
  input  logic            dostring_clk,
  input  logic            rst_n,
  input  logic            frame_painted,
  output led_pkg::phase_t top_blue,
  output led_pkg::phase_t top_green,
  output led_pkg::phase_t top_red,
  output led_pkg::phase_t middle_blue,
  output led_pkg::phase_t middle_green,
  output led_pkg::phase_t middle_red,
  output led_pkg::phase_t bottom_blue,
  output led_pkg::phase_t bottom_green,
  output led_pkg::phase_t bottom_red,
  output led_pkg::phase_t frame_idx
);
  import led_pkg::*;

  // Increments are smaller than the table, so one subtraction wraps it
  function automatic phase_t step_phase(phase_t phase, phase_t inc);
    logic [6:0] sum;
    sum = {1'b0, phase} + {1'b0, inc};
    if (sum >= 7'(`SINE_STEPS))
    begin
      sum = sum - 7'(`SINE_STEPS);
    end
    return phase_t'(sum);
  endfunction

  always_ff @(posedge dostring_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      top_blue     <= phase_t'(`START_TOP_BLUE);
      top_green    <= phase_t'(`START_TOP_GREEN);
      top_red      <= phase_t'(`START_TOP_RED);
      middle_blue  <= phase_t'(`START_MIDDLE_BLUE);
      middle_green <= phase_t'(`START_MIDDLE_GREEN);
      middle_red   <= phase_t'(`START_MIDDLE_RED);
      bottom_blue  <= phase_t'(`START_BOTTOM_BLUE);
      bottom_green <= phase_t'(`START_BOTTOM_GREEN);
      bottom_red   <= phase_t'(`START_BOTTOM_RED);
      frame_idx    <= '0;
    end
    else if (frame_painted)
    begin
      top_blue     <= step_phase(top_blue, phase_t'(`INC_TOP_BLUE));
      top_green    <= step_phase(top_green, phase_t'(`INC_TOP_GREEN));
      top_red      <= step_phase(top_red, phase_t'(`INC_TOP_RED));
      middle_blue  <= step_phase(middle_blue, phase_t'(`INC_MIDDLE_BLUE));
      middle_green <= step_phase(middle_green, phase_t'(`INC_MIDDLE_GREEN));
      middle_red   <= step_phase(middle_red, phase_t'(`INC_MIDDLE_RED));
      bottom_blue  <= step_phase(bottom_blue, phase_t'(`INC_BOTTOM_BLUE));
      bottom_green <= step_phase(bottom_green, phase_t'(`INC_BOTTOM_GREEN));
      bottom_red   <= step_phase(bottom_red, phase_t'(`INC_BOTTOM_RED));
      frame_idx    <= step_phase(frame_idx, phase_t'(1));
    end
  end

endmodule

`default_nettype wire

// ==== design/led_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Common types for the LED wave generator: levels, indices, the
// state and record enums, and the sine lookup shared by the painter.
// Compile before any module of the design.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "led_cfg.svh"

package led_pkg;

  typedef logic [7:0] level_t;
  typedef logic [5:0] pixel_idx_t;
  typedef logic [5:0] phase_t;
  typedef logic [7:0] byte_addr_t;

  typedef enum logic [1:0] {rec_start, rec_pixel, rec_end} record_kind_e;

  typedef enum logic [1:0] {band_top, band_middle, band_bottom} band_e;

  typedef enum logic [1:0] {paint_idle, paint_write, paint_done} paint_state_e;

  typedef enum logic {copy_idle, copy_run} copy_state_e;

  typedef enum logic [2:0] {
    send_idle,
    send_start,
    send_pixel,
    send_end,
    send_release
  } send_state_e;

  // One full period, peak at phases 11 to 13 and floor at 34 to 36
  localparam level_t SINE_TABLE [`SINE_STEPS] = '{
    50, 56, 62, 68, 75, 80, 85, 89, 93, 96,
    98, 99, 99, 99, 97, 95, 92, 88, 84, 78,
    72, 67, 60, 53, 47, 40, 33, 28, 22, 16,
    12,  8,  4,  2,  0,  0,  0,  1,  3,  5,
     9, 14, 18, 24, 30, 36, 43
  };

  function automatic level_t sine_level(phase_t phase);
    level_t lvl;
    lvl = '0;
    if (phase < `SINE_STEPS)
    begin
      lvl = SINE_TABLE[phase];
    end
    return lvl;
  endfunction

endpackage

`default_nettype wire

// ==== design/led_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time constants for the LED wave generator: strip length,
// sine table size, sender credit depth and the band phase settings.
// Include this wherever one of the constants is needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef LED_CFG_SVH
`define LED_CFG_SVH

`define LED_PIXELS 47
`define SINE_STEPS 47
`define CREDIT_MAX 4

// Start phases, already reduced modulo the sine table size
`define START_TOP_BLUE 10
`define START_TOP_GREEN 0
`define START_TOP_RED 20
`define START_MIDDLE_BLUE 3
`define START_MIDDLE_GREEN 30
`define START_MIDDLE_RED 23
`define START_BOTTOM_BLUE 30
`define START_BOTTOM_GREEN 40
`define START_BOTTOM_RED 0

// Per-frame phase steps
`define INC_TOP_BLUE 3
`define INC_TOP_GREEN 2
`define INC_TOP_RED 1
`define INC_MIDDLE_BLUE 2
`define INC_MIDDLE_GREEN 1
`define INC_MIDDLE_RED 3
`define INC_BOTTOM_BLUE 1
`define INC_BOTTOM_GREEN 2
`define INC_BOTTOM_RED 2

`define MIDDLE_OFFSET 5

`endif
